//--- Makefile
# Verilator lint and simulation for the AMO subsystem

VERILATOR ?= verilator
TOP       ?= amo_tb
FILELIST  ?= amo_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Fails unless the pass message shows up in the simulation output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- amo_subsys.f
+incdir+src
src/amo_op_pkg.sv
src/amo_fsm_pkg.sv
src/amo_buffer.sv
src/amo_alu.sv
src/amo_mem.sv
src/amo_ctrl.sv
src/amo_subsys.sv
verif/amo_props.sv
verif/amo_checker.sv
verif/amo_tb.sv

//--- src/amo_alu.sv
/*
 * Combinational compute of the value written back by an atomic operation.
 * Takes the old memory word, the request operand and the opcode.
 * The old word itself is what the subsystem returns as the response.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_alu
    import amo_op_pkg::*;
(
    input  amo_op_e                op_i,
    input  logic [`AMO_DATA_W-1:0] old_i,      // Word read from memory
    input  logic [`AMO_DATA_W-1:0] operand_i,  // Request data
    output logic [`AMO_DATA_W-1:0] new_o       // Word to store
);

    logic old_gt_s;  // Old above operand, signed
    logic old_gt_u;  // Old above operand, unsigned

    assign old_gt_s = $signed(old_i) > $signed(operand_i);
    assign old_gt_u = old_i > operand_i;

    always_comb begin
        case (op_i)
            SWAP:    new_o = operand_i;
            ADD:     new_o = old_i + operand_i;  // Wraps with no overflow flag
            AND:     new_o = old_i & operand_i;
            OR:      new_o = old_i | operand_i;
            XOR:     new_o = old_i ^ operand_i;
            MAX:     new_o = old_gt_s ? old_i : operand_i;
            MAXU:    new_o = old_gt_u ? old_i : operand_i;
            MIN:     new_o = old_gt_s ? operand_i : old_i;
            MINU:    new_o = old_gt_u ? operand_i : old_i;
            default: new_o = operand_i;          // Unused codes behave as swap
        endcase
    end

    // Equal values give the same result for max and min,
    // so the strict compare is enough

endmodule

//--- src/amo_buffer.sv
/*
 * Single-entry holding register for one atomic request.
 * Accepts a request while empty and keeps it until the controller pops it.
 * A pipeline flush drops the entry while it is still speculative.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_buffer
    import amo_op_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,       // Pipeline flush pulse
    input  logic                   commit_i,      // AMO has reached commit
    input  logic                   valid_i,       // Producer has a request
    input  amo_op_e                amo_op_i,
    input  logic [`AMO_ADDR_W-1:0] addr_i,
    input  logic [`AMO_DATA_W-1:0] data_i,
    input  logic                   start_i,       // Controller left IDLE
    input  logic                   pop_i,         // Response accepted
    output logic                   ready_o,       // High while empty
    output logic                   entry_valid_o,
    output amo_op_e                entry_op_o,
    output logic [`AMO_ADDR_W-1:0] entry_addr_o,
    output logic [`AMO_DATA_W-1:0] entry_data_o
);

    logic                   valid_q;      // Entry occupied
    amo_op_e                op_q;
    logic [`AMO_ADDR_W-1:0] addr_q;
    logic [`AMO_DATA_W-1:0] data_q;
    logic                   push;
    logic                   drop;

    assign ready_o = ~valid_q;
    assign push    = valid_i & ready_o;               // Handshake on the request port

    // Still speculative while neither committed nor started
    assign drop = flush_i & ~commit_i & ~start_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (drop || pop_i) begin
            valid_q <= 1'b0;                          // Flush wins over a same-cycle push
        end else if (push) begin
            valid_q <= 1'b1;
        end
    end

    // Payload is only meaningful while valid_q is set
    always_ff @(posedge clk_i) begin
        if (push) begin
            op_q   <= amo_op_i;
            addr_q <= addr_i;
            data_q <= data_i;
        end
    end

    assign entry_valid_o = valid_q;
    assign entry_op_o    = op_q;
    assign entry_addr_o  = addr_q;
    assign entry_data_o  = data_q;

endmodule

//--- src/amo_ctrl.sv
/*
 * Sequencer for one atomic read-modify-write.
 * Waits in IDLE for a committed entry with no older store pending,
 * then reads the word, writes the ALU result and returns the old value.
 * The entry is popped on the response handshake.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_ctrl
    import amo_fsm_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   entry_valid_i,    // Buffer holds a request
    input  logic                   commit_i,
    input  logic                   no_st_pending_i,
    input  logic                   resp_ready_i,     // Consumer takes the response
    input  logic [`AMO_DATA_W-1:0] rd_data_i,        // Registered memory read
    output logic                   start_o,          // Operation under way
    output logic                   pop_o,            // Free the buffer entry
    output logic                   mem_rd_en_o,
    output logic                   mem_wr_en_o,
    output logic                   resp_valid_o,
    output logic [`AMO_DATA_W-1:0] resp_data_o       // Old memory value
);

    amo_state_e             state_q;
    amo_state_e             state_d;
    logic                   issue;               // Entry may leave the buffer
    logic [`AMO_DATA_W-1:0] resp_data_q;

    // Entry is no longer speculative and all earlier stores have drained
    assign issue = entry_valid_i & commit_i & no_st_pending_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (issue) begin
                    state_d = READ;
                end
            end
            READ: begin
                state_d = WRITE;                 // Read data lands this edge
            end
            WRITE: begin
                state_d = RESP;
            end
            RESP: begin
                if (resp_ready_i) begin
                    state_d = IDLE;              // Handshake done
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Capture the old value while it sits on the read port
    always_ff @(posedge clk_i) begin
        if (state_q == WRITE) begin
            resp_data_q <= rd_data_i;
        end
    end

    assign start_o      = (state_q != IDLE);        // Blocks flush from here on
    assign mem_rd_en_o  = (state_q == READ);
    assign mem_wr_en_o  = (state_q == WRITE);       // Stores the ALU result
    assign resp_valid_o = (state_q == RESP);
    assign resp_data_o  = resp_data_q;
    assign pop_o        = (state_q == RESP) & resp_ready_i;

endmodule

//--- src/amo_fsm_pkg.sv
/*
 * Controller state encoding for the AMO sequencer.
 * Used by the controller and by the bound property module.
 */

package amo_fsm_pkg;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // Waiting for a committed entry
        READ  = 2'd1,  // Memory read issued
        WRITE = 2'd2,  // Old value back, new value written
        RESP  = 2'd3   // Response held until accepted
    } amo_state_e;

endpackage

//--- src/amo_macros.svh
/*
 * Width and depth macros for the atomic memory operation subsystem.
 * Include this wherever a data word or a word address is declared.
 * AMO_ADDR_W must cover AMO_MEM_WORDS when the depth is changed.
 */

`ifndef AMO_MACROS_SVH
`define AMO_MACROS_SVH

// Data word width in bits
`define AMO_DATA_W 32

// Number of words in the data memory
`define AMO_MEM_WORDS 16

// Word address width as log2 of the word count
`define AMO_ADDR_W 4

`endif

//--- src/amo_mem.sv
/*
 * Word-addressed data memory for the AMO subsystem.
 * Reads are registered so rd_data_o is valid the cycle after rd_en_i.
 * Writes land at the clock edge, and reset clears every word.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_mem (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   rd_en_i,
    input  logic                   wr_en_i,
    input  logic [`AMO_ADDR_W-1:0] addr_i,     // Shared read and write address
    input  logic [`AMO_DATA_W-1:0] wr_data_i,
    output logic [`AMO_DATA_W-1:0] rd_data_o
);

    logic [`AMO_DATA_W-1:0] mem_q [`AMO_MEM_WORDS];
    logic [`AMO_DATA_W-1:0] rd_data_q;

    // Storage array zeroed on reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `AMO_MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[addr_i] <= wr_data_i;
        end
    end

    // Registered read port
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_q <= mem_q[addr_i];  // Holds until the next read
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

//--- src/amo_op_pkg.sv
/*
 * Atomic operation encodings.
 * Shared by the request buffer, the ALU, the top level and the testbench.
 * Import with a wildcard in the module header.
 */

package amo_op_pkg;

    // Read-modify-write operations, one full word each
    typedef enum logic [3:0] {
        SWAP = 4'h0,  // Store operand
        ADD  = 4'h1,  // Old plus operand
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        MAX  = 4'h5,  // Signed maximum
        MAXU = 4'h6,  // Unsigned maximum
        MIN  = 4'h7,  // Signed minimum
        MINU = 4'h8   // Unsigned minimum
    } amo_op_e;

    // Encodings 4'h9 to 4'hf are unused
    // and the ALU treats them like SWAP

endpackage

//--- src/amo_subsys.sv
/*
 * Top level of the atomic memory operation subsystem.
 * Connects the request buffer, the controller, the ALU and the data memory.
 * Requests enter on a valid/ready port, the old word leaves on another.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_subsys
    import amo_op_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    input  amo_op_e                amo_op_i,
    input  logic [`AMO_ADDR_W-1:0] addr_i,
    input  logic [`AMO_DATA_W-1:0] data_i,
    input  logic                   commit_i,
    input  logic                   no_st_pending_i,
    input  logic                   resp_ready_i,
    output logic                   ready_o,
    output logic                   resp_valid_o,
    output logic [`AMO_DATA_W-1:0] resp_data_o
);

    logic                   entry_valid;
    amo_op_e                entry_op;
    logic [`AMO_ADDR_W-1:0] entry_addr;   // Memory address for both accesses
    logic [`AMO_DATA_W-1:0] entry_data;   // ALU operand
    logic                   start;
    logic                   pop;
    logic                   mem_rd_en;
    logic                   mem_wr_en;
    logic [`AMO_DATA_W-1:0] rd_data;      // Old word
    logic [`AMO_DATA_W-1:0] new_data;     // Word written back

    amo_buffer i_amo_buffer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .commit_i      (commit_i),
        .valid_i       (valid_i),
        .amo_op_i      (amo_op_i),
        .addr_i        (addr_i),
        .data_i        (data_i),
        .start_i       (start),
        .pop_i         (pop),
        .ready_o       (ready_o),
        .entry_valid_o (entry_valid),
        .entry_op_o    (entry_op),
        .entry_addr_o  (entry_addr),
        .entry_data_o  (entry_data)
    );

    amo_ctrl i_amo_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .entry_valid_i   (entry_valid),
        .commit_i        (commit_i),
        .no_st_pending_i (no_st_pending_i),
        .resp_ready_i    (resp_ready_i),
        .rd_data_i       (rd_data),
        .start_o         (start),
        .pop_o           (pop),
        .mem_rd_en_o     (mem_rd_en),
        .mem_wr_en_o     (mem_wr_en),
        .resp_valid_o    (resp_valid_o),
        .resp_data_o     (resp_data_o)
    );

    amo_alu i_amo_alu (
        .op_i      (entry_op),
        .old_i     (rd_data),
        .operand_i (entry_data),
        .new_o     (new_data)
    );

    amo_mem i_amo_mem (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_en_i   (mem_rd_en),
        .wr_en_i   (mem_wr_en),
        .addr_i    (entry_addr),
        .wr_data_i (new_data),
        .rd_data_o (rd_data)
    );

endmodule

//--- verif/amo_checker.sv
/*
 * Response checker for the AMO testbench.
 * Samples the DUT ports on the falling edge, follows the one request in
 * flight and compares each old value with the queued expected value.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_checker (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   valid_i,
    input  logic                   ready_i,         // DUT ready_o
    input  logic                   commit_i,
    input  logic                   no_st_pending_i,
    input  logic                   flush_i,
    input  logic                   resp_valid_i,
    input  logic                   resp_ready_i,
    input  logic [`AMO_DATA_W-1:0] resp_data_i,
    input  logic                   exp_push_i,      // Queue exp_data_i this cycle
    input  logic [`AMO_DATA_W-1:0] exp_data_i,
    output int                     pass_cnt_o,
    output int                     fail_cnt_o,
    output int                     outstanding_o    // Expected values not yet used
);

    logic [`AMO_DATA_W-1:0] exp_q[$];
    logic [`AMO_DATA_W-1:0] held_data;
    logic [`AMO_DATA_W-1:0] exp_v;
    logic in_reset = 1'b0;
    logic pending  = 1'b0;  // Accepted but no response yet
    logic issued   = 1'b0;  // Commit and store gating met
    logic dropped  = 1'b0;  // Flushed on the last edge
    logic held     = 1'b0;  // Response stalled at the last sample
    logic test_bad = 1'b0;
    int   edges    = 0;     // Edges since issue or zero once checked
    int   test_id  = 0;
    int   pass_cnt = 0;
    int   fail_cnt = 0;

    task automatic flag_error(input string msg);
        $display("FAIL at %0t: test %0d, %s", $time, test_id, msg);
        test_bad = 1'b1;
    endtask

    task automatic close_test(input logic ok, input string msg);
        if (ok && !test_bad) begin
            $display("PASS test %0d: %s", test_id, msg);
            pass_cnt++;
        end else begin
            $display("FAIL at %0t: test %0d, %s", $time, test_id, msg);
            fail_cnt++;
        end
        test_bad = 1'b0;
    endtask

    always @(negedge clk_i) begin
        if (rst_i) begin
            in_reset = 1'b1;
            pending  = 1'b0;
            held     = 1'b0;
        end else begin
            if (in_reset) begin  // Test 0 is the reset state
                in_reset = 1'b0;
                close_test(ready_i && !resp_valid_i, $sformatf(
                    "after reset ready_o %b resp_valid_o %b", ready_i, resp_valid_i));
            end
            if (exp_push_i)
                exp_q.push_back(exp_data_i);
            if (held && (!resp_valid_i || resp_data_i !== held_data))
                flag_error("response changed while stalled");
            held      = resp_valid_i && !resp_ready_i;
            held_data = resp_data_i;
            if (dropped) begin
                dropped = 1'b0;
                close_test(ready_i && !resp_valid_i, "flushed request dropped, ready_o back");
            end
            if (pending && ready_i)
                flag_error("ready_o high while a request is held");
            if (pending && !issued) begin
                if (resp_valid_i)
                    flag_error("response before commit and store drain");
                if (flush_i && !commit_i) begin  // Still speculative
                    pending = 1'b0;
                    dropped = 1'b1;
                end else if (commit_i && no_st_pending_i) begin
                    issued = 1'b1;
                    edges  = 1;  // Condition edge counts as the first
                end
            end else if (issued && edges != 0) begin
                if (!resp_valid_i) begin
                    edges++;
                end else begin
                    if (edges != 3)
                        flag_error($sformatf("resp_valid_o after %0d edges, expected 3", edges));
                    edges = 0;
                end
            end
            if (resp_valid_i && resp_ready_i) begin
                if (exp_q.size() == 0) begin
                    close_test(1'b0, "response with no expected value");
                end else begin
                    exp_v = exp_q.pop_front();
                    close_test(resp_data_i === exp_v, $sformatf(
                        "old value %h, expected %h", resp_data_i, exp_v));
                end
                pending = 1'b0;
                issued  = 1'b0;
            end
            if (valid_i && ready_i) begin  // New request accepted
                test_id++;
                pending = 1'b1;
                issued  = 1'b0;
                edges   = 0;
            end
        end
        pass_cnt_o    = pass_cnt;
        fail_cnt_o    = fail_cnt;
        outstanding_o = exp_q.size();
    end

endmodule

//--- verif/amo_props.sv
/*
 * Concurrent assertions on the AMO controller, bound into amo_ctrl.
 * Covers response stability under back-pressure, exclusive memory
 * enables and the condition for leaving IDLE.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_props
    import amo_fsm_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_i,
    input amo_state_e             state_i,
    input logic                   entry_valid_i,
    input logic                   resp_valid_i,
    input logic                   resp_ready_i,
    input logic [`AMO_DATA_W-1:0] resp_data_i,
    input logic                   mem_rd_en_i,
    input logic                   mem_wr_en_i
);

    int assert_fails = 0;  // Number of assertion failures

    // Old value holds while the consumer stalls
    resp_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
        else begin
            $error("Response dropped or changed during a stall");
            assert_fails++;
        end

    rd_wr_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_rd_en_i && mem_wr_en_i))
        else begin
            $error("Memory read and write enabled together");
            assert_fails++;
        end

    // An empty buffer keeps the FSM parked
    idle_exit_a: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i == IDLE && !entry_valid_i |=> state_i == IDLE)
        else begin
            $error("Controller left IDLE with an empty buffer");
            assert_fails++;
        end

endmodule

bind amo_ctrl amo_props i_amo_props (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .state_i       (state_q),
    .entry_valid_i (entry_valid_i),
    .resp_valid_i  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_data_i   (resp_data_o),
    .mem_rd_en_i   (mem_rd_en_o),
    .mem_wr_en_i   (mem_wr_en_o)
);

//--- verif/amo_stimulus.txt
# opcode(hex) addr(hex) operand(hex) commit_delay(dec) flush(dec) expected_old(hex)
# flush 0 none, 1 before commit so the request is dropped, 2 after commit so it completes
0 1 80000010 2 0 00000000
5 1 00000020 0 0 80000010
6 1 90000000 1 0 00000020
7 1 00000004 0 0 90000000
8 1 00000004 3 0 90000000
0 1 00000000 0 0 00000004
1 2 0000000f 0 0 00000000
1 2 fffffff2 1 0 0000000f
3 2 000000f0 0 0 00000001
2 2 0000003c 2 0 000000f1
4 2 000000ff 0 0 00000030
0 2 12345678 0 0 000000cf
0 3 deadbeef 2 1 00000000
3 3 00000000 0 0 00000000
0 2 aaaa5555 1 2 12345678
1 2 00000001 0 0 aaaa5555
7 4 fffffffe 0 0 00000000
6 4 00000001 0 0 fffffffe
8 4 7fffffff 1 0 fffffffe
5 4 80000000 0 0 7fffffff
0 4 00000000 0 0 7fffffff
2 f ffffffff 0 0 00000000

//--- verif/amo_tb.sv
/*
 * Testbench top for the AMO subsystem.
 * Reads operations and expected old values from verif/amo_stimulus.txt,
 * drives them with random store gating and response stalls,
 * and hands the comparing to amo_checker.
 */

`timescale 1ns/100ps

`include "amo_macros.svh"

module amo_tb
    import amo_op_pkg::*;
();

    localparam int    WAIT_LIMIT = 64;  // Cycles per wait
    localparam string STIM_FILE  = "verif/amo_stimulus.txt";

    logic                   clk_i, rst_i, flush_i, valid_i;
    amo_op_e                amo_op_i;
    logic [`AMO_ADDR_W-1:0] addr_i;
    logic [`AMO_DATA_W-1:0] data_i;
    logic                   commit_i, no_st_pending_i, resp_ready_i;
    logic                   ready_o, resp_valid_o;
    logic [`AMO_DATA_W-1:0] resp_data_o;
    logic                   exp_push;     // One cycle per expected value
    logic [`AMO_DATA_W-1:0] exp_data;
    int                     pass_cnt, fail_cnt, outstanding;
    int                     run_errors = 0;  // Timeouts and file trouble
    int                     n_ops = 0;

    amo_subsys i_dut (.*);

    amo_checker i_checker (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .valid_i         (valid_i),
        .ready_i         (ready_o),
        .commit_i        (commit_i),
        .no_st_pending_i (no_st_pending_i),
        .flush_i         (flush_i),
        .resp_valid_i    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .resp_data_i     (resp_data_o),
        .exp_push_i      (exp_push),
        .exp_data_i      (exp_data),
        .pass_cnt_o      (pass_cnt),
        .fail_cnt_o      (fail_cnt),
        .outstanding_o   (outstanding)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Just past the next rising edge
    task automatic step();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic wait_for(input bit resp);
        int n;
        n = 0;
        while (!(resp ? resp_valid_o : ready_o) && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!(resp ? resp_valid_o : ready_o)) begin
            $display("Timed out at %0t waiting for %s", $time, resp ? "resp_valid_o" : "ready_o");
            run_errors++;
        end
    endtask

    task automatic run_op(input logic [3:0] op, input logic [`AMO_ADDR_W-1:0] addr,
                          input logic [`AMO_DATA_W-1:0] operand, input int delay,
                          input int flush, input logic [`AMO_DATA_W-1:0] expv);
        int hold;
        wait_for(1'b0);
        if (run_errors != 0)
            return;
        valid_i  = 1'b1;
        amo_op_i = amo_op_e'(op);
        addr_i   = addr;
        data_i   = operand;
        exp_push = (flush != 1);  // Dropped request returns nothing
        exp_data = expv;
        step();
        valid_i  = 1'b0;
        exp_push = 1'b0;
        repeat (delay) step();    // Still speculative
        if (flush == 1) begin
            flush_i = 1'b1;
            step();
            flush_i = 1'b0;
            wait_for(1'b0);
            return;
        end
        commit_i        = 1'b1;
        no_st_pending_i = 1'b0;   // Older stores draining
        flush_i         = (flush == 2);
        hold = (flush == 2) ? 1 + $urandom % 3 : $urandom % 4;
        repeat (hold) begin
            step();
            flush_i = 1'b0;
        end
        no_st_pending_i = 1'b1;
        wait_for(1'b1);
        if (run_errors != 0)
            return;
        hold = $urandom % 5;      // Consumer stall
        repeat (hold) step();
        resp_ready_i = 1'b1;
        step();
        resp_ready_i = 1'b0;
        commit_i     = 1'b0;
    endtask

    initial begin
        int                     fd;
        string                  line;
        logic [3:0]             op;
        logic [`AMO_ADDR_W-1:0] addr;
        logic [`AMO_DATA_W-1:0] operand;
        logic [`AMO_DATA_W-1:0] expv;
        int                     delay;
        int                     flush;
        int                     bad;

        void'($urandom(32'h6fb492ae));
        rst_i           = 1'b1;
        flush_i         = 1'b0;
        valid_i         = 1'b0;
        amo_op_i        = SWAP;
        addr_i          = '0;
        data_i          = '0;
        commit_i        = 1'b0;
        no_st_pending_i = 1'b1;
        resp_ready_i    = 1'b0;
        exp_push        = 1'b0;
        exp_data        = '0;
        repeat (4) @(posedge clk_i);
        #0.5;
        rst_i = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            run_errors++;
        end else begin
            while (!$feof(fd) && run_errors == 0) begin
                // Comment and blank lines give fewer than six fields
                if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h %d %d %h",
                        op, addr, operand, delay, flush, expv) == 6) begin
                    n_ops++;
                    run_op(op, addr, operand, delay, flush, expv);
                end
            end
            $fclose(fd);
        end
        repeat (2) step();  // Checker sees the last edge

        bad = fail_cnt + run_errors;
        if (i_dut.i_amo_ctrl.i_amo_props.assert_fails != 0) begin
            $display("%0d controller assertions failed",
                     i_dut.i_amo_ctrl.i_amo_props.assert_fails);
            bad++;
        end
        if (outstanding != 0) begin
            $display("%0d expected values never met a response", outstanding);
            bad++;
        end
        if (pass_cnt + fail_cnt != n_ops + 1) begin
            $display("Only %0d results for %0d operations", pass_cnt + fail_cnt, n_ops);
            bad++;
        end
        $display("Summary: %0d passed, %0d failed, %0d run errors",
                 pass_cnt, fail_cnt, run_errors);
        if (bad == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
